// File: verilog/bpredConfigPkg.sv
// Branch predictor configuration
// Default address width and table sizes, passed down from the top level

package bpredConfigPkg;

  // Address width of the fetch and execute PCs
  parameter int XLEN = 32;

  // log2 of the number of two-bit counters
  parameter int DirIndexBits = 6;

  // log2 of the number of BTB entries
  parameter int BtbIndexBits = 4;

  // Return address stack entries
  // wraps around, so need not be a power of two
  parameter int RasDepth = 4;

endpackage

// File: verilog/bpredClassPkg.sv
// Instruction class encoding
// One bit per class, shared by the BTB, the direction table and the top level

package bpredClassPkg;

  // Width of the class field
  parameter int ClassWidth = 4;

  // Bit positions inside the class field
  parameter int ClassBranch = 0;
  parameter int ClassJump   = 1;
  // Jump with rs1 = x1 or x5
  parameter int ClassReturn = 2;
  // Jump with rd = x1 or x5
  parameter int ClassCall   = 3;

  // Link register test
  // x1 = 00001 and x5 = 00101 differ only in bit 2
  parameter logic [4:0] LinkRegMask  = 5'b11011;
  parameter logic [4:0] LinkRegValue = 5'b00001;

  // Reset state of every direction counter
  parameter logic [1:0] CounterWeakNotTaken = 2'b01;

endpackage

// File: verilog/twoBitPredictor.sv
`timescale 1ns/1ps

// Two-bit saturating counter direction predictor
// Registered lookup in fetch, counter update in execute from the real outcome

module twoBitPredictor #(
  parameter int XLEN         = bpredConfigPkg::XLEN,
  parameter int DirIndexBits = bpredConfigPkg::DirIndexBits
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            StallF,
  input  logic            StallD,
  input  logic            StallE,
  input  logic            FlushD,
  input  logic            FlushE,
  input  logic [XLEN-1:0] PCNextF,
  input  logic [XLEN-1:0] PCE,
  input  logic            BranchInstrE,
  input  logic            PCSrcE,
  output logic [1:0]      DirPredictionF,
  output logic            DirPredictionWrongE
);

  import bpredClassPkg::*;

  localparam int Entries = 2 ** DirIndexBits;

  logic [1:0]              DirTable [Entries];
  logic [DirIndexBits-1:0] LookIndex, UpdIndex;
  logic [1:0]              OldCount, NewCount;
  // Only the taken bit is carried down the pipe
  logic                    DirPredictionD, DirPredictionE;

  // Word aligned PCs, so skip the low two bits
  assign LookIndex = PCNextF[DirIndexBits+1:2];
  assign UpdIndex  = PCE[DirIndexBits+1:2];

  // Saturating step toward the real outcome
  assign OldCount = DirTable[UpdIndex];
  always_comb begin
    if (PCSrcE) begin
      NewCount = (OldCount == 2'b11) ? 2'b11 : OldCount + 2'b01;
    end else begin
      NewCount = (OldCount == 2'b00) ? 2'b00 : OldCount - 2'b01;
    end
  end

  // Counter table, written only by a branch leaving execute
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < Entries; i++) begin
        DirTable[i] <= CounterWeakNotTaken;
      end
    end else if (~StallE & BranchInstrE) begin
      DirTable[UpdIndex] <= NewCount;
    end
  end

  // Fetch read, old contents on a same-entry write
  always_ff @(posedge clk) begin
    if (rst) begin
      DirPredictionF <= CounterWeakNotTaken;
    end else if (~StallF) begin
      DirPredictionF <= DirTable[LookIndex];
    end
  end

  // F to D to E, flush acts only when the stage advances
  always_ff @(posedge clk) begin
    if (rst) begin
      DirPredictionD <= 1'b0;
      DirPredictionE <= 1'b0;
    end else begin
      if (~StallD) DirPredictionD <= FlushD ? 1'b0 : DirPredictionF[1];
      if (~StallE) DirPredictionE <= FlushE ? 1'b0 : DirPredictionD;
    end
  end

  assign DirPredictionWrongE = BranchInstrE & (DirPredictionE != PCSrcE);

endmodule

// File: verilog/btb.sv
`timescale 1ns/1ps

// Branch target buffer
// Direct-mapped, untagged; predicts target address and instruction class
// Looked up from PCNextF, trained from the execute stage

module btb #(
  parameter int XLEN         = bpredConfigPkg::XLEN,
  parameter int BtbIndexBits = bpredConfigPkg::BtbIndexBits
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 StallF,
  input  logic                                 StallE,
  input  logic [XLEN-1:0]                      PCNextF,
  input  logic [XLEN-1:0]                      PCE,
  input  logic [XLEN-1:0]                      IEUAdrE,
  input  logic [bpredClassPkg::ClassWidth-1:0] InstrClassE,
  input  logic                                 AnyWrongPredInstrClassE,
  output logic [XLEN-1:0]                      PredPCF,
  output logic [bpredClassPkg::ClassWidth-1:0] BTBPredInstrClassF,
  output logic                                 PredValidF
);

  import bpredClassPkg::*;

  localparam int Entries = 2 ** BtbIndexBits;

  logic                    ValidTable  [Entries];
  logic [XLEN-1:0]         TargetTable [Entries];
  logic [ClassWidth-1:0]   ClassTable  [Entries];
  logic [BtbIndexBits-1:0] LookIndex, UpdIndex;
  logic                    UpdateEn, HitValid;

  assign LookIndex = PCNextF[BtbIndexBits+1:2];
  assign UpdIndex  = PCE[BtbIndexBits+1:2];

  // Train on any control transfer in E
  // also on a plain instruction the BTB called a CFI, whose zero class
  // then kills the stale prediction
  assign UpdateEn = ~StallE & ((|InstrClassE) | AnyWrongPredInstrClassE);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < Entries; i++) begin
        ValidTable[i] <= 1'b0;
      end
    end else if (UpdateEn) begin
      ValidTable[UpdIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (UpdateEn) begin
      TargetTable[UpdIndex] <= IEUAdrE;
      ClassTable[UpdIndex]  <= InstrClassE;
    end
  end

  // Fetch read
  // An invalid entry reads back as zero target and no class
  assign HitValid = ValidTable[LookIndex];
  always_ff @(posedge clk) begin
    if (rst) begin
      PredValidF         <= 1'b0;
      PredPCF            <= '0;
      BTBPredInstrClassF <= '0;
    end else if (~StallF) begin
      PredValidF         <= HitValid;
      PredPCF            <= HitValid ? TargetTable[LookIndex] : '0;
      BTBPredInstrClassF <= HitValid ? ClassTable[LookIndex] : '0;
    end
  end

endmodule

// File: verilog/rasPredictor.sv
`timescale 1ns/1ps

// Return address stack
// Circular stack of link addresses, updated from execute only
// The top entry is the return prediction used in fetch

module rasPredictor #(
  parameter int XLEN     = bpredConfigPkg::XLEN,
  parameter int RasDepth = bpredConfigPkg::RasDepth
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 StallE,
  input  logic [bpredClassPkg::ClassWidth-1:0] InstrClassE,
  input  logic [XLEN-1:0]                      PCLinkE,
  output logic [XLEN-1:0]                      RASPCF
);

  import bpredClassPkg::*;

  localparam int PtrBits = (RasDepth > 1) ? $clog2(RasDepth) : 1;
  localparam logic [PtrBits-1:0] LastPtr = PtrBits'(RasDepth - 1);

  logic [XLEN-1:0]    Stack [RasDepth];
  // Ptr points at the current top entry
  logic [PtrBits-1:0] Ptr, PopPtr, PushBase, PushPtr, NextPtr;
  logic               PopE, PushE;

  assign PopE  = ~StallE & InstrClassE[ClassReturn];
  assign PushE = ~StallE & InstrClassE[ClassCall];

  // Wrap modulo RasDepth in both directions
  assign PopPtr   = (Ptr == '0) ? LastPtr : Ptr - 1'b1;
  // Pop first, then push on top of what is left
  assign PushBase = PopE ? PopPtr : Ptr;
  assign PushPtr  = (PushBase == LastPtr) ? '0 : PushBase + 1'b1;
  assign NextPtr  = PushE ? PushPtr : (PopE ? PopPtr : Ptr);

  // Full stack push overwrites the oldest entry
  always_ff @(posedge clk) begin
    if (rst) begin
      Ptr <= '0;
      for (int i = 0; i < RasDepth; i++) begin
        Stack[i] <= '0;
      end
    end else begin
      Ptr <= NextPtr;
      if (PushE) Stack[PushPtr] <= PCLinkE;
    end
  end

  assign RASPCF = Stack[Ptr];

endmodule

// File: verilog/bpred.sv
`timescale 1ns/1ps

// Branch prediction unit for a five-stage RISC-V pipeline
// Predicts the next fetch address, corrects it in execute
// and reports the outcome of each prediction to the memory stage

module bpred #(
  parameter int XLEN         = bpredConfigPkg::XLEN,
  parameter int DirIndexBits = bpredConfigPkg::DirIndexBits,
  parameter int BtbIndexBits = bpredConfigPkg::BtbIndexBits,
  parameter int RasDepth     = bpredConfigPkg::RasDepth
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 StallF,
  input  logic                                 StallD,
  input  logic                                 StallE,
  input  logic                                 StallM,
  input  logic                                 FlushD,
  input  logic                                 FlushE,
  input  logic                                 FlushM,
  input  logic [XLEN-1:0]                      PCNextF,
  input  logic [XLEN-1:0]                      PCPlus4F,
  input  logic [XLEN-1:0]                      PCF,
  input  logic [XLEN-1:0]                      PCD,
  input  logic [XLEN-1:0]                      PCE,
  input  logic [31:0]                          InstrD,
  input  logic                                 InstrValidD,
  input  logic                                 InstrValidE,
  input  logic                                 BranchD,
  input  logic                                 JumpD,
  input  logic                                 PCSrcE,
  input  logic [XLEN-1:0]                      IEUAdrE,
  input  logic [XLEN-1:0]                      PCLinkE,
  output logic [XLEN-1:0]                      PCNext1F,
  output logic                                 BPPredWrongE,
  output logic                                 BPPredWrongM,
  output logic [bpredClassPkg::ClassWidth-1:0] InstrClassM,
  output logic                                 JumpOrTakenBranchM,
  output logic                                 DirPredictionWrongM,
  output logic                                 BTBPredPCWrongM,
  output logic                                 RASPredPCWrongM,
  output logic                                 PredictionInstrClassWrongM
);

  import bpredClassPkg::*;

  // Fetch
  logic [1:0]            DirPredictionF;
  logic                  PredValidF, SelBPPredF;
  logic [ClassWidth-1:0] BTBPredInstrClassF;
  logic [XLEN-1:0]       PredPCF, RASPCF, BPPredPCF, PCNext0F;
  // Decode
  logic [ClassWidth-1:0] InstrClassD, PredInstrClassD;
  logic                  AnyWrongPredInstrClassD;
  logic [XLEN-1:0]       PredPCD, RASPCD;
  // Execute
  logic [ClassWidth-1:0] InstrClassE;
  logic                  AnyWrongPredInstrClassE, DirPredictionWrongE;
  logic                  BTBPredPCWrongE, RASPredPCWrongE, JumpOrTakenBranchE;
  logic [XLEN-1:0]       PredPCE, RASPCE, PCCorrectE;

  ////////////////////////////////////////////////////////////////////////////
  // Predictor tables
  ////////////////////////////////////////////////////////////////////////////

  twoBitPredictor #(.XLEN(XLEN), .DirIndexBits(DirIndexBits)) dirPred_i (
    .clk, .rst, .StallF, .StallD, .StallE, .FlushD, .FlushE,
    .PCNextF, .PCE, .BranchInstrE(InstrClassE[ClassBranch]), .PCSrcE,
    .DirPredictionF, .DirPredictionWrongE
  );

  btb #(.XLEN(XLEN), .BtbIndexBits(BtbIndexBits)) btb_i (
    .clk, .rst, .StallF, .StallE, .PCNextF, .PCE, .IEUAdrE, .InstrClassE,
    .AnyWrongPredInstrClassE, .PredPCF, .BTBPredInstrClassF, .PredValidF
  );

  rasPredictor #(.XLEN(XLEN), .RasDepth(RasDepth)) ras_i (
    .clk, .rst, .StallE, .InstrClassE, .PCLinkE, .RASPCF
  );

  ////////////////////////////////////////////////////////////////////////////
  // Fetch address select
  ////////////////////////////////////////////////////////////////////////////

  // Class always comes from the BTB
  assign SelBPPredF = PredValidF &
                      (BTBPredInstrClassF[ClassJump] |
                       (BTBPredInstrClassF[ClassBranch] & DirPredictionF[1]));

  assign BPPredPCF  = BTBPredInstrClassF[ClassReturn] ? RASPCF : PredPCF;
  assign PCNext0F   = SelBPPredF ? BPPredPCF : PCPlus4F;
  // Correction from execute wins
  assign PCNext1F   = BPPredWrongE ? PCCorrectE : PCNext0F;

  ////////////////////////////////////////////////////////////////////////////
  // Decode class and execute check
  ////////////////////////////////////////////////////////////////////////////

  assign InstrClassD[ClassBranch] = BranchD;
  assign InstrClassD[ClassJump]   = JumpD;
  assign InstrClassD[ClassReturn] = JumpD & ((InstrD[19:15] & LinkRegMask) == LinkRegValue);
  assign InstrClassD[ClassCall]   = JumpD & ((InstrD[11:7] & LinkRegMask) == LinkRegValue);

  // BTB class disagrees with the decoded class
  assign AnyWrongPredInstrClassD = |(PredInstrClassD ^ InstrClassD);

  // Target or fall-through, then PCD tells what was fetched next
  assign PCCorrectE   = PCSrcE ? IEUAdrE : PCLinkE;
  assign BPPredWrongE = (PCCorrectE != PCD) & InstrValidE & InstrValidD;

  // Accuracy of the BTB and RAS measured on their own pipelined guesses
  assign BTBPredPCWrongE = (PredPCE != IEUAdrE) & PCSrcE &
                           (InstrClassE[ClassBranch] |
                            (InstrClassE[ClassJump] & ~InstrClassE[ClassReturn]));
  assign RASPredPCWrongE = (RASPCE != IEUAdrE) & PCSrcE & InstrClassE[ClassReturn];

  assign JumpOrTakenBranchE = (InstrClassE[ClassBranch] & PCSrcE) | InstrClassE[ClassJump];

  ////////////////////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////////////////////

  // Flush acts only when the stage advances

  // F to D
  always_ff @(posedge clk) begin
    if (rst) begin
      PredInstrClassD <= '0;
      PredPCD         <= '0;
      RASPCD          <= '0;
    end else if (~StallD) begin
      PredInstrClassD <= FlushD ? '0 : BTBPredInstrClassF;
      PredPCD         <= FlushD ? '0 : PredPCF;
      RASPCD          <= FlushD ? '0 : RASPCF;
    end
  end

  // D to E
  always_ff @(posedge clk) begin
    if (rst) begin
      InstrClassE             <= '0;
      AnyWrongPredInstrClassE <= 1'b0;
      PredPCE                 <= '0;
      RASPCE                  <= '0;
    end else if (~StallE) begin
      InstrClassE             <= FlushE ? '0 : InstrClassD;
      AnyWrongPredInstrClassE <= FlushE ? 1'b0 : AnyWrongPredInstrClassD;
      PredPCE                 <= FlushE ? '0 : PredPCD;
      RASPCE                  <= FlushE ? '0 : RASPCD;
    end
  end

  // E to M status flags
  always_ff @(posedge clk) begin
    if (rst) begin
      InstrClassM                <= '0;
      BPPredWrongM               <= 1'b0;
      JumpOrTakenBranchM         <= 1'b0;
      DirPredictionWrongM        <= 1'b0;
      BTBPredPCWrongM            <= 1'b0;
      RASPredPCWrongM            <= 1'b0;
      PredictionInstrClassWrongM <= 1'b0;
    end else if (~StallM) begin
      InstrClassM                <= FlushM ? '0 : InstrClassE;
      BPPredWrongM               <= ~FlushM & BPPredWrongE;
      JumpOrTakenBranchM         <= ~FlushM & JumpOrTakenBranchE;
      DirPredictionWrongM        <= ~FlushM & DirPredictionWrongE;
      BTBPredPCWrongM            <= ~FlushM & BTBPredPCWrongE;
      RASPredPCWrongM            <= ~FlushM & RASPredPCWrongE;
      PredictionInstrClassWrongM <= ~FlushM & AnyWrongPredInstrClassE;
    end
  end

endmodule

// File: test/bpred_checker.sv
`timescale 1ns/1ps

// Branch predictor assertion checker
// Bound into bpred, watches the class encoding and the misprediction flags

module bpredChecker (
  input logic                                 clk,
  input logic                                 rst,
  input logic                                 InstrValidE,
  input logic                                 BPPredWrongE,
  input logic                                 BPPredWrongM,
  input logic [bpredClassPkg::ClassWidth-1:0] InstrClassM,
  input logic                                 JumpOrTakenBranchM,
  input logic                                 DirPredictionWrongM,
  input logic                                 BTBPredPCWrongM,
  input logic                                 RASPredPCWrongM,
  input logic                                 PredictionInstrClassWrongM
);

  import bpredClassPkg::*;

  // Return and call are kinds of jump
  assert property (@(posedge clk) disable iff (rst)
    (InstrClassM[ClassReturn] | InstrClassM[ClassCall]) |-> InstrClassM[ClassJump])
    else $error("Return or call class in M without the jump bit");

  // A correction needs a real instruction in execute
  assert property (@(posedge clk) BPPredWrongE |-> InstrValidE)
    else $error("BPPredWrongE raised without InstrValidE");

  // Memory stage comes out of reset quiet
  assert property (@(posedge clk) rst |=>
    !(BPPredWrongM | JumpOrTakenBranchM | DirPredictionWrongM | BTBPredPCWrongM |
      RASPredPCWrongM | PredictionInstrClassWrongM | (|InstrClassM)))
    else $error("Memory stage flags not clear after reset");

endmodule

bind bpred bpredChecker checker_i (
  .clk, .rst, .InstrValidE, .BPPredWrongE, .BPPredWrongM, .InstrClassM,
  .JumpOrTakenBranchM, .DirPredictionWrongM, .BTBPredPCWrongM, .RASPredPCWrongM,
  .PredictionInstrClassWrongM
);

// File: test/bpredTb.sv
`timescale 1ns/1ps

// Branch prediction unit testbench
// LFSR driven random pipeline traffic, checked against a cycle model
// of the counters, the BTB, the return stack and the stage registers

module bpredTb;

  import bpredConfigPkg::*;
  import bpredClassPkg::*;

  localparam int NumCycles  = 2000;
  // Reset plus test cycles, with some slack
  localparam int CycleLimit = NumCycles + 20;
  localparam int DirEntries = 2 ** DirIndexBits;
  localparam int BtbEntries = 2 ** BtbIndexBits;

  logic clk, rst;
  logic StallF, StallD, StallE, StallM, FlushD, FlushE, FlushM;
  logic [XLEN-1:0] PCNextF, PCPlus4F, PCF, PCD, PCE, IEUAdrE, PCLinkE;
  logic [31:0] InstrD;
  logic InstrValidD, InstrValidE, BranchD, JumpD, PCSrcE;
  logic [XLEN-1:0] PCNext1F;
  logic BPPredWrongE, BPPredWrongM, JumpOrTakenBranchM, DirPredictionWrongM;
  logic BTBPredPCWrongM, RASPredPCWrongM, PredictionInstrClassWrongM;
  logic [ClassWidth-1:0] InstrClassM;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////////////////////

  logic [1:0]            dirTab    [DirEntries];
  logic                  btbValid  [BtbEntries];
  logic [XLEN-1:0]       btbTarget [BtbEntries];
  logic [ClassWidth-1:0] btbClass  [BtbEntries];
  logic [XLEN-1:0]       rasStack  [RasDepth];
  int                    rasPtr;
  // Registered fetch reads
  logic [1:0]            dirF;
  logic                  validF;
  logic [XLEN-1:0]       predPcF;
  logic [ClassWidth-1:0] predClsF;
  // Decode and execute copies
  logic                  dirD, dirE, clsWrongE;
  logic [ClassWidth-1:0] predClsD, clsE;
  logic [XLEN-1:0]       predPcD, rasD, predPcE, rasE;
  // Memory stage flags
  logic [ClassWidth-1:0] clsM;
  logic wrongM, jtbM, dirWrongM, btbWrongM, rasWrongM, clsWrongM;
  // PCs held by the fetch and execute stages of the pipeline around the DUT
  logic [XLEN-1:0] heldPcf, heldPce;
  logic            expWrongE;

  logic [15:0] lfsr;
  // Fetch, execute and memory error counts
  int          errCount [3];
  int          cycles;

  bpred #(
    .XLEN(XLEN), .DirIndexBits(DirIndexBits), .BtbIndexBits(BtbIndexBits),
    .RasDepth(RasDepth)
  ) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // Eight neighbouring word addresses, so PC+4 often lands in the set
  function automatic logic [XLEN-1:0] pickAddr(input logic [2:0] sel);
    return XLEN'(32'h0000_2000) + XLEN'({sel, 2'b00});
  endfunction

  // Class from opcode kind and the x1/x5 link register fields
  function automatic logic [ClassWidth-1:0] decodeClass(input logic br, input logic jp,
                                                        input logic [31:0] instr);
    logic [ClassWidth-1:0] cls;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    rd  = instr[11:7];
    rs1 = instr[19:15];
    cls = '0;
    cls[ClassBranch] = br;
    cls[ClassJump]   = jp;
    cls[ClassReturn] = jp && (rs1 == 5'd1 || rs1 == 5'd5);
    cls[ClassCall]   = jp && (rd == 5'd1 || rd == 5'd5);
    return cls;
  endfunction

  task automatic compareOutput(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp, input int kind);
    assert (got === exp) else begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
      errCount[kind]++;
    end
  endtask

  task automatic resetModel();
    for (int i = 0; i < DirEntries; i++) begin
      dirTab[i] = CounterWeakNotTaken;
    end
    for (int i = 0; i < BtbEntries; i++) begin
      btbValid[i]  = 1'b0;
      btbTarget[i] = '0;
      btbClass[i]  = '0;
    end
    for (int i = 0; i < RasDepth; i++) begin
      rasStack[i] = '0;
    end
    rasPtr = 0;
    dirF = CounterWeakNotTaken;
    {validF, predPcF, predClsF} = '0;
    {dirD, predClsD, predPcD, rasD} = '0;
    {dirE, clsWrongE, clsE, predPcE, rasE} = '0;
    {clsM, wrongM, jtbM, dirWrongM, btbWrongM, rasWrongM, clsWrongM} = '0;
    heldPcf   = '0;
    heldPce   = '0;
    expWrongE = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic driveInputs();
    logic [2:0] kind;
    logic [4:0] linkReg, rdRand, rs1Rand, rd, rs1;
    kind    = 3'(takeBits(3));
    linkReg = takeBits(1) != 0 ? 5'd5 : 5'd1;
    rdRand  = 5'(takeBits(5));
    rs1Rand = 5'(takeBits(5));
    // 0..2 plain, 3 branch, 4 jump, 5 call, 6 return, 7 call and return
    BranchD = (kind == 3'd3);
    JumpD   = (kind >= 3'd4);
    rd      = (kind == 3'd5 || kind == 3'd7) ? linkReg : rdRand;
    rs1     = (kind == 3'd6 || kind == 3'd7) ? linkReg : rs1Rand;
    InstrD  = {12'h000, rs1, 3'b000, rd,
               JumpD ? 7'b1101111 : (BranchD ? 7'b1100011 : 7'b0010011)};
    PCNextF     = pickAddr(3'(takeBits(3)));
    PCD         = pickAddr(3'(takeBits(3)));
    IEUAdrE     = pickAddr(3'(takeBits(3)));
    PCF         = heldPcf;
    PCPlus4F    = heldPcf + 4;
    PCE         = heldPce;
    PCLinkE     = heldPce + 4;
    // Jumps always taken, branches at random, plain never
    PCSrcE      = clsE[ClassJump] | (clsE[ClassBranch] & 1'(takeBits(1)));
    InstrValidD = takeBits(3) != 0;
    InstrValidE = takeBits(3) != 0;
    StallF      = takeBits(3) == 0;
    StallD      = takeBits(3) == 0;
    StallE      = takeBits(3) == 0;
    StallM      = takeBits(3) == 0;
    FlushD      = takeBits(3) == 0;
    FlushE      = takeBits(3) == 0;
    FlushM      = takeBits(3) == 0;
  endtask

  task automatic checkOutputs();
    logic [XLEN-1:0] correct, predAddr, expNext;
    logic            sel;
    correct   = PCSrcE ? IEUAdrE : PCLinkE;
    expWrongE = (correct != PCD) && InstrValidE && InstrValidD;
    sel       = validF && (predClsF[ClassJump] || (predClsF[ClassBranch] && dirF[1]));
    predAddr  = predClsF[ClassReturn] ? rasStack[rasPtr] : predPcF;
    if (expWrongE) expNext = correct;
    else if (sel) expNext = predAddr;
    else expNext = PCPlus4F;
    compareOutput("PCNext1F", PCNext1F, expNext, 0);
    compareOutput("BPPredWrongE", XLEN'(BPPredWrongE), XLEN'(expWrongE), 1);
    compareOutput("InstrClassM", XLEN'(InstrClassM), XLEN'(clsM), 2);
    compareOutput("BPPredWrongM", XLEN'(BPPredWrongM), XLEN'(wrongM), 2);
    compareOutput("JumpOrTakenBranchM", XLEN'(JumpOrTakenBranchM), XLEN'(jtbM), 2);
    compareOutput("DirPredictionWrongM", XLEN'(DirPredictionWrongM), XLEN'(dirWrongM), 2);
    compareOutput("BTBPredPCWrongM", XLEN'(BTBPredPCWrongM), XLEN'(btbWrongM), 2);
    compareOutput("RASPredPCWrongM", XLEN'(RASPredPCWrongM), XLEN'(rasWrongM), 2);
    compareOutput("PredictionInstrClassWrongM", XLEN'(PredictionInstrClassWrongM),
                  XLEN'(clsWrongM), 2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model step for the coming rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic stepModel();
    logic [ClassWidth-1:0] clsD, fCls;
    logic [XLEN-1:0]       oldTop, fPc;
    logic [1:0]            fDir, cnt;
    logic                  fValid, dirWrongE, btbWrongE, rasWrongE, jtbE;
    int                    ui, bu;
    clsD   = decodeClass(BranchD, JumpD, InstrD);
    oldTop = rasStack[rasPtr];
    dirWrongE = clsE[ClassBranch] && (dirE != PCSrcE);
    btbWrongE = (predPcE != IEUAdrE) && PCSrcE &&
                (clsE[ClassBranch] || (clsE[ClassJump] && !clsE[ClassReturn]));
    rasWrongE = (rasE != IEUAdrE) && PCSrcE && clsE[ClassReturn];
    jtbE      = (clsE[ClassBranch] && PCSrcE) || clsE[ClassJump];
    if (!StallM) begin
      clsM      = FlushM ? '0 : clsE;
      wrongM    = !FlushM && expWrongE;
      jtbM      = !FlushM && jtbE;
      dirWrongM = !FlushM && dirWrongE;
      btbWrongM = !FlushM && btbWrongE;
      rasWrongM = !FlushM && rasWrongE;
      clsWrongM = !FlushM && clsWrongE;
    end
    // Fetch read sees the tables before this edge's writes
    fDir   = dirTab[int'(PCNextF[DirIndexBits+1:2])];
    fValid = btbValid[int'(PCNextF[BtbIndexBits+1:2])];
    fPc    = fValid ? btbTarget[int'(PCNextF[BtbIndexBits+1:2])] : '0;
    fCls   = fValid ? btbClass[int'(PCNextF[BtbIndexBits+1:2])] : '0;
    if (!StallE) begin
      ui = int'(PCE[DirIndexBits+1:2]);
      bu = int'(PCE[BtbIndexBits+1:2]);
      // Saturating counter step
      if (clsE[ClassBranch]) begin
        cnt = dirTab[ui];
        if (PCSrcE && cnt != 2'b11) cnt = cnt + 2'b01;
        else if (!PCSrcE && cnt != 2'b00) cnt = cnt - 2'b01;
        dirTab[ui] = cnt;
      end
      if (clsE != '0 || clsWrongE) begin
        btbValid[bu]  = 1'b1;
        btbTarget[bu] = IEUAdrE;
        btbClass[bu]  = clsE;
      end
      // Pop before push, pointer wraps both ways
      if (clsE[ClassReturn]) rasPtr = (rasPtr + RasDepth - 1) % RasDepth;
      if (clsE[ClassCall]) begin
        rasPtr = (rasPtr + 1) % RasDepth;
        rasStack[rasPtr] = PCLinkE;
      end
      clsE      = FlushE ? '0 : clsD;
      clsWrongE = !FlushE && (predClsD != clsD);
      dirE      = !FlushE && dirD;
      predPcE   = FlushE ? '0 : predPcD;
      rasE      = FlushE ? '0 : rasD;
      heldPce   = PCD;
    end
    if (!StallD) begin
      dirD     = !FlushD && dirF[1];
      predClsD = FlushD ? '0 : predClsF;
      predPcD  = FlushD ? '0 : predPcF;
      rasD     = FlushD ? '0 : oldTop;
    end
    if (!StallF) begin
      dirF     = fDir;
      validF   = fValid;
      predPcF  = fPc;
      predClsF = fCls;
      heldPcf  = PCNextF;
    end
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CycleLimit);
    $display("Something failed");
    $finish;
  end

  initial begin
    int total;
    lfsr = 16'd52010;
    errCount[0] = 0;
    errCount[1] = 0;
    errCount[2] = 0;
    rst = 1'b1;
    {StallF, StallD, StallE, StallM, FlushD, FlushE, FlushM} = '0;
    {PCNextF, PCPlus4F, PCF, PCD, PCE, IEUAdrE, PCLinkE} = '0;
    InstrD = '0;
    {InstrValidD, InstrValidE, BranchD, JumpD, PCSrcE} = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    resetModel();
    for (int c = 0; c < NumCycles; c++) begin
      driveInputs();
      // Let the combinational paths settle before comparing
      #1;
      checkOutputs();
      stepModel();
      @(negedge clk);
    end
    total = errCount[0] + errCount[1] + errCount[2];
    $display("Error counts: fetch %0d, execute %0d, memory %0d",
             errCount[0], errCount[1], errCount[2]);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
verilog/bpredConfigPkg.sv
verilog/bpredClassPkg.sv
verilog/twoBitPredictor.sv
verilog/btb.sv
verilog/rasPredictor.sv
verilog/bpred.sv
test/bpred_checker.sv
test/bpredTb.sv

// File: run.sh
#!/bin/sh
# Build the branch predictor testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bpredTb \
  -f vlog.f -o bpredSim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/bpredSim > sim.log 2>&1
grep -qx "Everything OK" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
